// ==== hdl/cache_geom_pkg.sv ====
`default_nettype none

package cache_geom_pkg;

    // The upper bits of a line address are the tag and the lower bits pick the set
    localparam int TAG_W       = 9;
    localparam int INDEX_W     = 3;
    localparam int LINE_ADDR_W = TAG_W + INDEX_W;

    // A line is sixteen bytes, written under a per-byte enable
    localparam int LINE_BYTES = 16;
    localparam int LINE_W     = 8 * LINE_BYTES;

    localparam int NUM_SETS = 1 << INDEX_W;

    typedef logic [LINE_ADDR_W-1:0] line_addr_t;
    typedef logic [TAG_W-1:0]       cache_tag_t;
    typedef logic [INDEX_W-1:0]     cache_index_t;
    typedef logic [LINE_W-1:0]      cache_word_t;
    typedef logic [LINE_BYTES-1:0]  byte_mask_t;

    // Fills and write-backs always move the whole line
    localparam byte_mask_t FULL_MASK = '1;

endpackage : cache_geom_pkg

`default_nettype wire

// ==== hdl/cache_bus_pkg.sv ====
`default_nettype none

package cache_bus_pkg;

    // The processor holds this request until the cache answers with cpu_resp
    typedef struct packed {
        logic                         read;
        logic                         write;
        cache_geom_pkg::line_addr_t   addr;
        cache_geom_pkg::byte_mask_t   byte_sel;
        cache_geom_pkg::cache_word_t  wdata;
    } cpu_req_t;

    // The cache holds this request until the memory answers with mem_resp
    // Transfers are full lines, so no byte mask travels here
    typedef struct packed {
        logic                         read;
        logic                         write;
        cache_geom_pkg::line_addr_t   addr;
        cache_geom_pkg::cache_word_t  wdata;
    } mem_req_t;

endpackage : cache_bus_pkg

`default_nettype wire

// ==== hdl/cache_way.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_way (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         load,
    input  wire logic                         load_type,
    input  wire cache_geom_pkg::byte_mask_t   byte_sel,
    input  wire cache_geom_pkg::cache_tag_t   tag_in,
    input  wire cache_geom_pkg::cache_index_t index,
    input  wire cache_geom_pkg::cache_word_t  data_in,
    output cache_geom_pkg::cache_tag_t        tag_out,
    output cache_geom_pkg::cache_word_t       data_out,
    output logic                              dirty,
    output logic                              hit
);

    import cache_geom_pkg::*;

    cache_word_t         data_arr [NUM_SETS];
    cache_tag_t          tag_arr  [NUM_SETS];
    logic [NUM_SETS-1:0] valid_arr;
    logic [NUM_SETS-1:0] dirty_arr;

    // Only the enabled bytes of the line change on a load
    always_ff @(posedge clk) begin
        if (load) begin
            for (int i = 0; i < LINE_BYTES; i++) begin
                if (byte_sel[i]) begin
                    data_arr[index][8*i +: 8] <= data_in[8*i +: 8];
                end
            end
            tag_arr[index] <= tag_in;
        end
    end

    // load_type high means the line came from memory and is clean
    // A processor write keeps the line valid and marks it dirty
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_arr <= '0;
            dirty_arr <= '0;
        end else if (load) begin
            if (load_type) begin
                valid_arr[index] <= 1'b1;
                dirty_arr[index] <= 1'b0;
            end else begin
                dirty_arr[index] <= 1'b1;
            end
        end
    end

    // Read side is purely combinational from the index
    assign tag_out  = tag_arr[index];
    assign data_out = data_arr[index];
    assign dirty    = dirty_arr[index];
    assign hit      = valid_arr[index] && (tag_arr[index] == tag_in);

endmodule : cache_way

`default_nettype wire

// ==== hdl/cache_set.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_set (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        way_sel,
    input  wire logic                        data_source_sel,
    input  wire logic                        tag_bypass_sel,
    input  wire logic                        load,
    input  wire logic                        load_lru,
    input  wire cache_geom_pkg::line_addr_t  cpu_addr,
    input  wire cache_geom_pkg::byte_mask_t  cpu_byte_sel,
    input  wire cache_geom_pkg::cache_word_t cpu_wdata,
    input  wire cache_geom_pkg::cache_word_t mem_rdata,
    output logic                             hit_0,
    output logic                             hit_1,
    output logic                             dirty,
    output logic                             lru,
    output cache_geom_pkg::cache_word_t      rdata,
    output cache_geom_pkg::line_addr_t       mem_addr
);

    import cache_geom_pkg::*;

    cache_tag_t   tag_in;
    cache_index_t index;
    cache_word_t  data_in;
    byte_mask_t   byte_sel;
    cache_word_t  data_0;
    cache_word_t  data_1;
    cache_tag_t   tag_0;
    cache_tag_t   tag_1;
    cache_tag_t   tag_out;
    logic         dirty_0;
    logic         dirty_1;
    logic         load_0;
    logic         load_1;

    logic [NUM_SETS-1:0] lru_arr;

    assign {tag_in, index} = cpu_addr;

    // Data comes from the processor under its own mask or as a full memory line
    assign data_in  = data_source_sel ? mem_rdata : cpu_wdata;
    assign byte_sel = data_source_sel ? FULL_MASK : cpu_byte_sel;

    // Only the selected way sees the load strobe
    assign load_0 = load & ~way_sel;
    assign load_1 = load & way_sel;

    cache_way i_way_0 (
        .clk, .rst, .load(load_0), .load_type(data_source_sel), .byte_sel, .tag_in,
        .index, .data_in, .tag_out(tag_0), .data_out(data_0), .dirty(dirty_0), .hit(hit_0)
    );

    cache_way i_way_1 (
        .clk, .rst, .load(load_1), .load_type(data_source_sel), .byte_sel, .tag_in,
        .index, .data_in, .tag_out(tag_1), .data_out(data_1), .dirty(dirty_1), .hit(hit_1)
    );

    // Same line goes to the processor and, during write-back, to memory
    assign rdata   = way_sel ? data_1 : data_0;
    assign tag_out = way_sel ? tag_1 : tag_0;

    // Write-back uses the stored tag and fills use the requested tag
    assign mem_addr = {tag_bypass_sel ? tag_in : tag_out, index};

    // The victim candidate is the way that was not used last
    assign lru   = lru_arr[index];
    assign dirty = lru ? dirty_1 : dirty_0;

    always_ff @(posedge clk) begin
        if (rst) begin
            lru_arr <= '0;
        end else if (load_lru) begin
            lru_arr[index] <= ~way_sel;
        end
    end

endmodule : cache_set

`default_nettype wire

// ==== hdl/cache_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_control (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic cpu_read,
    input  wire logic cpu_write,
    input  wire logic hit_0,
    input  wire logic hit_1,
    input  wire logic dirty,
    input  wire logic lru,
    input  wire logic mem_resp,
    output logic      way_sel,
    output logic      data_source_sel,
    output logic      tag_bypass_sel,
    output logic      load,
    output logic      load_lru,
    output logic      cpu_resp,
    output logic      mem_read,
    output logic      mem_write
);

    typedef enum logic [1:0] {
        idle       = 2'd0,
        write_back = 2'd1,
        allocate   = 2'd2
    } state_t;

    state_t state;
    state_t state_next;
    logic   cpu_req;
    logic   hit;

    assign cpu_req = cpu_read | cpu_write;
    assign hit     = hit_0 | hit_1;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                // On a miss the victim is the LRU way, written back first if dirty
                if (cpu_req && !hit) begin
                    state_next = dirty ? write_back : allocate;
                end
            end
            write_back: if (mem_resp) state_next = allocate;
            allocate:   if (mem_resp) state_next = idle;
            default:    state_next = idle;
        endcase
    end

    // Memory strobes depend on the state alone
    // The hit response and hit loads follow the way compares in idle
    always_comb begin
        way_sel         = lru;
        data_source_sel = 1'b0;
        tag_bypass_sel  = 1'b1;
        load            = 1'b0;
        load_lru        = 1'b0;
        cpu_resp        = 1'b0;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        case (state)
            idle: begin
                way_sel = hit_1;
                if (cpu_req && hit) begin
                    cpu_resp = 1'b1;
                    load_lru = 1'b1;
                    load     = cpu_write;
                end
            end
            write_back: begin
                tag_bypass_sel = 1'b0;
                mem_write      = 1'b1;
            end
            allocate: begin
                data_source_sel = 1'b1;
                mem_read        = 1'b1;
                load            = mem_resp;
            end
            default: ;
        endcase
    end

endmodule : cache_control

`default_nettype wire

// ==== hdl/cache.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire cache_bus_pkg::cpu_req_t     cpu_req,
    input  wire logic                        mem_resp,
    input  wire cache_geom_pkg::cache_word_t mem_rdata,
    output logic                             cpu_resp,
    output cache_geom_pkg::cache_word_t      cpu_rdata,
    output cache_bus_pkg::mem_req_t          mem_req
);

    import cache_geom_pkg::*;

    logic        way_sel;
    logic        data_source_sel;
    logic        tag_bypass_sel;
    logic        load;
    logic        load_lru;
    logic        hit_0;
    logic        hit_1;
    logic        dirty;
    logic        lru;
    logic        mem_read;
    logic        mem_write;
    line_addr_t  mem_addr;
    cache_word_t rdata;

    cache_control i_control (
        .clk, .rst, .cpu_read(cpu_req.read), .cpu_write(cpu_req.write), .hit_0, .hit_1,
        .dirty, .lru, .mem_resp, .way_sel, .data_source_sel, .tag_bypass_sel, .load,
        .load_lru, .cpu_resp, .mem_read, .mem_write
    );

    cache_set i_set (
        .clk, .rst, .way_sel, .data_source_sel, .tag_bypass_sel, .load, .load_lru,
        .cpu_addr(cpu_req.addr), .cpu_byte_sel(cpu_req.byte_sel), .cpu_wdata(cpu_req.wdata),
        .mem_rdata, .hit_0, .hit_1, .dirty, .lru, .rdata, .mem_addr
    );

    // The selected line feeds both the processor and write-back data
    assign cpu_rdata = rdata;
    assign mem_req   = '{read: mem_read, write: mem_write, addr: mem_addr, wdata: rdata};

endmodule : cache

`default_nettype wire

// ==== verif/cache_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_assertions (
    input wire logic clk,
    input wire logic rst,
    input wire logic in_idle,
    input wire logic cpu_resp,
    input wire logic mem_read,
    input wire logic mem_write,
    input wire logic mem_resp
);

    // Memory sees one transfer direction at a time
    strobes_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(mem_read && mem_write)
    ) else $error("mem_read and mem_write are high together");

    // Hits are answered only from idle
    resp_only_in_idle: assert property (
        @(posedge clk) disable iff (rst) cpu_resp |-> in_idle
    ) else $error("cpu_resp is high outside idle");

    read_held: assert property (
        @(posedge clk) disable iff (rst) (mem_read && !mem_resp) |=> mem_read
    ) else $error("mem_read dropped before mem_resp");

    write_held: assert property (
        @(posedge clk) disable iff (rst) (mem_write && !mem_resp) |=> mem_write
    ) else $error("mem_write dropped before mem_resp");

endmodule : cache_assertions

`default_nettype wire

// ==== verif/cache_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_tb;

    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    localparam int SEED         = 72643;
    localparam int RESET_CYCLES = 5;
    localparam int MAX_DELAY    = 4;
    localparam int MEM_LINES    = 4096;
    localparam int NUM_TESTS    = 11;
    localparam int IDLE_CHECKS  = 3;
    localparam int CYCLE_LIMIT  = NUM_TESTS * (2 + 2 * MAX_DELAY + 2) + RESET_CYCLES;

    typedef struct packed {
        logic        write;
        line_addr_t  addr;
        byte_mask_t  mask;
        cache_word_t wdata;
        int          exp_reads;
        int          exp_writes;
        line_addr_t  victim;
    } access_t;

    logic        clk;
    logic        rst;
    cpu_req_t    cpu_req;
    logic        cpu_resp;
    cache_word_t cpu_rdata;
    mem_req_t    mem_req;
    logic        mem_resp  = 1'b0;
    cache_word_t mem_rdata = '0;

    cache_word_t mem_arr    [MEM_LINES];
    cache_word_t shadow_arr [MEM_LINES];
    access_t     tests      [NUM_TESTS];
    int          mem_reads    = 0;
    int          mem_writes   = 0;
    line_addr_t  last_wr_addr = '0;
    logic        mem_busy     = 1'b0;
    int          mem_wait     = 0;
    int          cycle_cnt    = 0;

    cache i_cache (
        .clk, .rst, .cpu_req, .mem_resp, .mem_rdata, .cpu_resp, .cpu_rdata, .mem_req
    );

    bind cache_control cache_assertions i_assertions (
        .clk(clk), .rst(rst), .in_idle(state == idle), .cpu_resp(cpu_resp),
        .mem_read(mem_read), .mem_write(mem_write), .mem_resp(mem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input cache_word_t got, input cache_word_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input line_addr_t got, input line_addr_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            stop_with_error($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // Memory answers each request after 1 to MAX_DELAY cycles with a one-cycle pulse
    always @(posedge clk) begin
        if (rst) begin
            mem_arr   <= shadow_arr;
            mem_resp  <= 1'b0;
            mem_busy  <= 1'b0;
            mem_wait  <= 0;
        end else if (mem_resp) begin
            // The cache leaves its memory state at this same edge
            mem_resp <= 1'b0;
            mem_busy <= 1'b0;
        end else if (mem_busy) begin
            if (mem_wait == 0) begin
                mem_resp <= 1'b1;
                if (mem_req.write) begin
                    mem_arr[mem_req.addr] <= mem_req.wdata;
                    last_wr_addr          <= mem_req.addr;
                    mem_writes            <= mem_writes + 1;
                end else begin
                    mem_rdata <= mem_arr[mem_req.addr];
                    mem_reads <= mem_reads + 1;
                end
            end else begin
                mem_wait <= mem_wait - 1;
            end
        end else if (mem_req.read || mem_req.write) begin
            mem_busy <= 1'b1;
            mem_wait <= $urandom_range(MAX_DELAY - 1, 0);
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            stop_with_error($sformatf("Timeout: run still busy after %0d cycles", CYCLE_LIMIT));
        end
    end

    // Applies a byte mask the way a processor write is defined to act on a line
    function automatic cache_word_t merge_bytes(input cache_word_t old_line,
                                                input cache_word_t new_line,
                                                input byte_mask_t  mask);
        cache_word_t result;
        result = old_line;
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (mask[b]) begin
                result[8*b +: 8] = new_line[8*b +: 8];
            end
        end
        return result;
    endfunction

    // Tags 0x012, 0x034 and 0x056 all map to index 3; 0x7C5 sits alone in set 5
    task automatic load_table();
        // write, addr, mask, wdata, memory reads, memory writes, victim address
        tests[0]  = '{1'b0, 12'h7C5, 16'h0000, '0, 1, 0, 12'h000};
        tests[1]  = '{1'b0, 12'h7C5, 16'h0000, '0, 0, 0, 12'h000};
        tests[2]  = '{1'b1, 12'h7C5, 16'h00F0,
                      128'h01234567_89ABCDEF_FEDCBA98_76543210, 0, 0, 12'h000};
        tests[3]  = '{1'b0, 12'h7C5, 16'h0000, '0, 0, 0, 12'h000};
        tests[4]  = '{1'b1, 12'h093, 16'h0F0F,
                      128'hDEADBEEF_CAFEF00D_0BADC0DE_FEEDFACE, 1, 0, 12'h000};
        tests[5]  = '{1'b0, 12'h1A3, 16'h0000, '0, 1, 0, 12'h000};
        tests[6]  = '{1'b0, 12'h093, 16'h0000, '0, 0, 0, 12'h000};
        tests[7]  = '{1'b0, 12'h2B3, 16'h0000, '0, 1, 0, 12'h000};
        tests[8]  = '{1'b0, 12'h093, 16'h0000, '0, 0, 0, 12'h000};
        tests[9]  = '{1'b0, 12'h1A3, 16'h0000, '0, 1, 0, 12'h000};
        tests[10] = '{1'b0, 12'h2B3, 16'h0000, '0, 1, 1, 12'h093};
    endtask

    task automatic run_access(input access_t t);
        int          reads_before;
        int          writes_before;
        cache_word_t got;
        reads_before  = mem_reads;
        writes_before = mem_writes;
        @(posedge clk);
        cpu_req <= '{read: !t.write, write: t.write, addr: t.addr, byte_sel: t.mask,
                     wdata: t.wdata};
        do begin
            @(negedge clk);
        end while (!cpu_resp);
        got = cpu_rdata;
        @(posedge clk);
        cpu_req <= '0;
        if (t.write) begin
            shadow_arr[t.addr] = merge_bytes(shadow_arr[t.addr], t.wdata, t.mask);
        end else begin
            check_word("cpu_rdata", got, shadow_arr[t.addr]);
        end
        check_count("memory reads", mem_reads - reads_before, t.exp_reads);
        check_count("memory writes", mem_writes - writes_before, t.exp_writes);
        if (t.exp_writes != 0) begin
            check_addr("mem_req.addr", last_wr_addr, t.victim);
            check_word("mem_req.wdata", mem_arr[t.victim], shadow_arr[t.victim]);
        end
    endtask

    initial begin
        cache_word_t line;
        void'($urandom(SEED));
        rst     <= 1'b1;
        cpu_req <= '0;
        // Memory copies this image during reset, so both start out equal
        for (int i = 0; i < MEM_LINES; i++) begin
            line          = {$urandom, $urandom, $urandom, $urandom};
            shadow_arr[i] = line;
        end
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        repeat (IDLE_CHECKS) begin
            @(negedge clk);
            check_bit("cpu_resp", cpu_resp, 1'b0);
            check_bit("mem_req.read", mem_req.read, 1'b0);
            check_bit("mem_req.write", mem_req.write, 1'b0);
        end
        for (int n = 0; n < NUM_TESTS; n++) begin
            run_access(tests[n]);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule : cache_tb

`default_nettype wire

// ==== compile.f ====
hdl/cache_geom_pkg.sv
hdl/cache_bus_pkg.sv
hdl/cache_way.sv
hdl/cache_set.sv
hdl/cache_control.sv
hdl/cache.sv
verif/cache_assertions.sv
verif/cache_tb.sv

// ==== Makefile ====
# Verilator flow for the cache testbench
VERILATOR ?= verilator
TOP       ?= cache_tb
RTL_TOP   ?= cache
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Result: PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
